/* include/cache_config.svh */
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// cpu address split: tag | index | offset
`define CACHE_TAG_W     20
`define CACHE_INDEX_W   8
`define CACHE_OFFSET_W  4

// line geometry
`define CACHE_WORDS     4    // 32-bit words per line

// set/way organization
`define CACHE_WAYS      2
`define CACHE_SETS      256  // must equal 2**CACHE_INDEX_W

`endif

/* source/cache_pkg.sv */
`include "cache_config.svh"

package cache_pkg;

    typedef logic [`CACHE_TAG_W-1:0]              tag_t;
    typedef logic [`CACHE_INDEX_W-1:0]            index_t;
    typedef logic [`CACHE_OFFSET_W-1:0]           offset_t;
    typedef logic [$clog2(`CACHE_WORDS)-1:0]      word_sel_t;
    typedef logic [31:0]                          word_t;
    typedef logic [3:0]                           strb_t;
    typedef logic [`CACHE_WORDS*32-1:0]           line_t;  // word 0 in bits 31:0
    typedef logic [31:0]                          addr_t;
    typedef logic                                 way_t;

    typedef enum logic [2:0]
    {
        IDLE,
        LOOKUP,
        MISS,
        REPLACE,
        REFILL
    } ctrl_state_t;

endpackage

/* source/cache_lookup.sv */
module cache_lookup (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 lookup_en,
    input  logic                 op,
    input  cache_pkg::tag_t      tag,
    input  cache_pkg::index_t    index,
    input  cache_pkg::offset_t   offset,
    input  cache_pkg::strb_t     wstrb,
    input  cache_pkg::word_t     wdata,
    input  cache_pkg::tag_t      way0_tag,
    input  cache_pkg::tag_t      way1_tag,
    input  logic                 way0_valid,
    input  logic                 way1_valid,
    input  logic                 way0_dirty,
    input  logic                 way1_dirty,
    input  cache_pkg::line_t     way0_line,
    input  cache_pkg::line_t     way1_line,
    input  cache_pkg::way_t      victim_ptr,
    output logic                 req_op,
    output cache_pkg::tag_t      req_tag,
    output cache_pkg::index_t    req_index,
    output cache_pkg::word_sel_t req_word,
    output cache_pkg::strb_t     req_wstrb,
    output cache_pkg::word_t     req_wdata,
    output logic                 hit,
    output cache_pkg::way_t      hit_way,
    output cache_pkg::way_t      victim_way,
    output logic                 victim_dirty,
    output cache_pkg::tag_t      victim_tag,
    output cache_pkg::line_t     victim_line
);

    logic way0_hit;
    logic way1_hit;

    // address part of the request buffer, kept defined so store reads are clean
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            req_op    <= 1'b0;
            req_tag   <= '0;
            req_index <= '0;
            req_word  <= '0;
        end
        else if (lookup_en)
        begin
            req_op    <= op;
            req_tag   <= tag;
            req_index <= index;
            req_word  <= offset[3:2];  // byte offset to word number
        end
    end

    always_ff @(posedge clk)
    begin
        if (lookup_en)
        begin
            req_wstrb <= wstrb;
            req_wdata <= wdata;
        end
    end

    assign way0_hit = way0_valid && (way0_tag == req_tag);
    assign way1_hit = way1_valid && (way1_tag == req_tag);
    assign hit      = way0_hit || way1_hit;
    assign hit_way  = way1_hit;

    // invalid ways are filled first, then the per-set pointer decides
    assign victim_way   = !way0_valid ? 1'b0 :
                          !way1_valid ? 1'b1 : victim_ptr;
    assign victim_dirty = victim_way ? way1_dirty : way0_dirty;
    assign victim_tag   = victim_way ? way1_tag   : way0_tag;
    assign victim_line  = victim_way ? way1_line  : way0_line;

endmodule

/* source/cache_way_store.sv */
`include "cache_config.svh"

module cache_way_store (
    input  logic                 clk,
    input  logic                 resetn,
    input  cache_pkg::index_t    req_index,
    input  logic                 store_we,
    input  cache_pkg::way_t      store_way,
    input  cache_pkg::line_t     store_line,
    input  logic                 refill_we,
    input  cache_pkg::way_t      refill_way,
    input  cache_pkg::word_sel_t refill_word,
    input  cache_pkg::word_t     refill_data,
    input  cache_pkg::tag_t      req_tag,
    input  logic                 req_op,
    output cache_pkg::tag_t      way0_tag,
    output cache_pkg::tag_t      way1_tag,
    output logic                 way0_valid,
    output logic                 way1_valid,
    output logic                 way0_dirty,
    output logic                 way1_dirty,
    output cache_pkg::line_t     way0_line,
    output cache_pkg::line_t     way1_line,
    output cache_pkg::way_t      victim_ptr
);

    localparam int WORD_W = $bits(cache_pkg::word_t);

    cache_pkg::tag_t        tag_mem  [`CACHE_WAYS][`CACHE_SETS];
    cache_pkg::line_t       data_mem [`CACHE_WAYS][`CACHE_SETS];
    logic [`CACHE_SETS-1:0] valid_bits [`CACHE_WAYS];
    logic [`CACHE_SETS-1:0] dirty_bits [`CACHE_WAYS];
    logic [`CACHE_SETS-1:0] ptr_bits;
    logic                   first_beat;
    logic                   last_beat;

    assign first_beat = refill_we && (refill_word == '0);
    assign last_beat  = refill_we &&
                        (refill_word == cache_pkg::word_sel_t'(`CACHE_WORDS - 1));

    always_ff @(posedge clk)
    begin
        if (store_we)
        begin
            data_mem[store_way][req_index] <= store_line;  // merged hit line
        end
        if (refill_we)
        begin
            data_mem[refill_way][req_index][refill_word*WORD_W +: WORD_W] <= refill_data;
        end
        if (first_beat)
        begin
            tag_mem[refill_way][req_index] <= req_tag;
        end
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            for (int w = 0; w < `CACHE_WAYS; w++)
            begin
                valid_bits[w] <= '0;
                dirty_bits[w] <= '0;
            end
            ptr_bits <= '0;
        end
        else
        begin
            if (store_we && req_op)
            begin
                dirty_bits[store_way][req_index] <= 1'b1;
            end
            if (first_beat)
            begin
                valid_bits[refill_way][req_index] <= 1'b1;
                dirty_bits[refill_way][req_index] <= 1'b0;  // fresh copy of memory
            end
            // both lines in use, so the next miss takes the other way
            if (last_beat && valid_bits[0][req_index] && valid_bits[1][req_index])
            begin
                ptr_bits[req_index] <= ~ptr_bits[req_index];
            end
        end
    end

    assign way0_tag   = tag_mem[0][req_index];
    assign way1_tag   = tag_mem[1][req_index];
    assign way0_valid = valid_bits[0][req_index];
    assign way1_valid = valid_bits[1][req_index];
    assign way0_dirty = dirty_bits[0][req_index];
    assign way1_dirty = dirty_bits[1][req_index];
    assign way0_line  = data_mem[0][req_index];
    assign way1_line  = data_mem[1][req_index];
    assign victim_ptr = ptr_bits[req_index];

endmodule

/* source/cache_miss_control.sv */
`include "cache_config.svh"

module cache_miss_control (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 valid,
    input  logic                 hit,
    input  cache_pkg::way_t      victim_way,
    input  logic                 victim_dirty,
    input  cache_pkg::tag_t      victim_tag,
    input  cache_pkg::line_t     victim_line,
    input  cache_pkg::tag_t      req_tag,
    input  cache_pkg::index_t    req_index,
    input  logic                 rd_rdy,
    input  logic                 ret_valid,
    input  logic                 ret_last,
    input  cache_pkg::word_t     ret_data,
    input  logic                 wr_rdy,
    output logic                 addr_ok,
    output logic                 lookup_en,
    output logic                 lookup_state,
    output logic                 rd_req,
    output cache_pkg::addr_t     rd_addr,
    output logic                 wr_req,
    output cache_pkg::addr_t     wr_addr,
    output cache_pkg::line_t     wr_data,
    output logic                 refill_we,
    output cache_pkg::way_t      refill_way,
    output cache_pkg::word_sel_t refill_word,
    output cache_pkg::word_t     refill_data
);

    cache_pkg::ctrl_state_t state;
    cache_pkg::ctrl_state_t next_state;
    logic                   miss_start;
    logic                   vic_dirty;
    cache_pkg::way_t        vic_way;
    cache_pkg::tag_t        vic_tag;
    cache_pkg::line_t       vic_line;
    cache_pkg::word_sel_t   beat_cnt;

    assign miss_start = (state == cache_pkg::LOOKUP) && !hit;

    always_comb
    begin
        next_state = state;
        case (state)
            cache_pkg::IDLE:    if (valid) next_state = cache_pkg::LOOKUP;
            cache_pkg::LOOKUP:  next_state = hit ? cache_pkg::IDLE : cache_pkg::MISS;
            cache_pkg::MISS:    if (!vic_dirty || wr_rdy) next_state = cache_pkg::REPLACE;
            cache_pkg::REPLACE: if (rd_rdy) next_state = cache_pkg::REFILL;
            cache_pkg::REFILL:  if (ret_valid && ret_last) next_state = cache_pkg::LOOKUP;
            default:            next_state = cache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state     <= cache_pkg::IDLE;
            vic_dirty <= 1'b0;
            beat_cnt  <= '0;
        end
        else
        begin
            state <= next_state;
            if (miss_start)
            begin
                vic_dirty <= victim_dirty;
            end
            if (state == cache_pkg::REPLACE)
            begin
                beat_cnt <= '0;
            end
            else if (refill_we)
            begin
                beat_cnt <= beat_cnt + 1'b1;  // beats arrive in word order
            end
        end
    end

    // victim held steady for the whole write-back and refill
    always_ff @(posedge clk)
    begin
        if (miss_start)
        begin
            vic_way  <= victim_way;
            vic_tag  <= victim_tag;
            vic_line <= victim_line;
        end
    end

    assign addr_ok      = (state == cache_pkg::IDLE);
    assign lookup_en    = addr_ok && valid;
    assign lookup_state = (state == cache_pkg::LOOKUP);

    assign wr_req  = (state == cache_pkg::MISS) && vic_dirty;
    assign wr_addr = {vic_tag, req_index, {`CACHE_OFFSET_W{1'b0}}};
    assign wr_data = vic_line;

    assign rd_req  = (state == cache_pkg::REPLACE);
    assign rd_addr = {req_tag, req_index, {`CACHE_OFFSET_W{1'b0}}};  // line address

    assign refill_we   = (state == cache_pkg::REFILL) && ret_valid;
    assign refill_way  = vic_way;
    assign refill_word = beat_cnt;
    assign refill_data = ret_data;

endmodule

/* source/cache_response.sv */
module cache_response (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 lookup_state,
    input  logic                 hit,
    input  cache_pkg::way_t      hit_way,
    input  logic                 req_op,
    input  cache_pkg::word_sel_t req_word,
    input  cache_pkg::strb_t     req_wstrb,
    input  cache_pkg::word_t     req_wdata,
    input  cache_pkg::line_t     way0_line,
    input  cache_pkg::line_t     way1_line,
    output logic                 data_ok,
    output cache_pkg::word_t     rdata,
    output logic                 store_we,
    output cache_pkg::way_t      store_way,
    output cache_pkg::line_t     store_line
);

    localparam int WORD_W = $bits(cache_pkg::word_t);

    cache_pkg::line_t hit_line;
    cache_pkg::word_t hit_word;
    cache_pkg::word_t byte_mask;
    logic             hit_done;

    assign hit_done  = lookup_state && hit;
    assign hit_line  = hit_way ? way1_line : way0_line;
    assign hit_word  = hit_line[req_word*WORD_W +: WORD_W];
    assign byte_mask = {{8{req_wstrb[3]}}, {8{req_wstrb[2]}},
                        {8{req_wstrb[1]}}, {8{req_wstrb[0]}}};

    always_comb
    begin
        store_line = hit_line;
        store_line[req_word*WORD_W +: WORD_W] = (req_wdata & byte_mask) |
                                                (hit_word & ~byte_mask);
    end

    assign store_we  = hit_done && req_op;
    assign store_way = hit_way;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            data_ok <= 1'b0;
        end
        else
        begin
            data_ok <= hit_done;  // single-cycle pulse
        end
    end

    always_ff @(posedge clk)
    begin
        if (hit_done)
        begin
            rdata <= hit_word;
        end
    end

endmodule

/* source/cache_top.sv */
module cache_top (
    input  logic                clk,
    input  logic                resetn,
    input  logic                valid,
    input  logic                op,      // 1 = write
    input  cache_pkg::tag_t     tag,
    input  cache_pkg::index_t   index,
    input  cache_pkg::offset_t  offset,
    input  cache_pkg::strb_t    wstrb,
    input  cache_pkg::word_t    wdata,
    output logic                addr_ok,
    output logic                data_ok,
    output cache_pkg::word_t    rdata,
    output logic                rd_req,
    output cache_pkg::addr_t    rd_addr,
    input  logic                rd_rdy,
    input  logic                ret_valid,
    input  logic                ret_last,
    input  cache_pkg::word_t    ret_data,
    output logic                wr_req,
    output cache_pkg::addr_t    wr_addr,
    output cache_pkg::line_t    wr_data,
    input  logic                wr_rdy
);

    logic                 lookup_en;
    logic                 lookup_state;
    logic                 req_op;
    cache_pkg::tag_t      req_tag;
    cache_pkg::index_t    req_index;
    cache_pkg::word_sel_t req_word;
    cache_pkg::strb_t     req_wstrb;
    cache_pkg::word_t     req_wdata;
    logic                 hit;
    cache_pkg::way_t      hit_way;
    cache_pkg::way_t      victim_way;
    logic                 victim_dirty;
    cache_pkg::tag_t      victim_tag;
    cache_pkg::line_t     victim_line;
    cache_pkg::way_t      victim_ptr;
    cache_pkg::tag_t      way0_tag;
    cache_pkg::tag_t      way1_tag;
    logic                 way0_valid;
    logic                 way1_valid;
    logic                 way0_dirty;
    logic                 way1_dirty;
    cache_pkg::line_t     way0_line;
    cache_pkg::line_t     way1_line;
    logic                 store_we;
    cache_pkg::way_t      store_way;
    cache_pkg::line_t     store_line;
    logic                 refill_we;
    cache_pkg::way_t      refill_way;
    cache_pkg::word_sel_t refill_word;
    cache_pkg::word_t     refill_data;

    cache_lookup u_lookup (.*);

    cache_way_store u_way_store (.*);

    cache_miss_control u_miss_control (.*);

    cache_response u_response (.*);

endmodule

/* tests/cache_assertions.sv */
module cache_assertions (
    input logic                   clk,
    input logic                   resetn,
    input cache_pkg::ctrl_state_t state,
    input logic                   addr_ok,
    input logic                   rd_req,
    input logic                   rd_rdy,
    input logic                   wr_req,
    input logic                   wr_rdy,
    input cache_pkg::addr_t       wr_addr,
    input cache_pkg::line_t       wr_data
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;  // failed assertions so far

    rd_req_held: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req)
        else
        begin
            $error("rd_req dropped before rd_rdy");
            fail_count++;
        end

    wr_req_held: assert property (@(posedge clk) disable iff (!resetn)
        wr_req && !wr_rdy |=> wr_req && $stable(wr_addr) && $stable(wr_data))
        else
        begin
            $error("wr_req dropped or write-back changed before wr_rdy");
            fail_count++;
        end

    one_request: assert property (@(posedge clk) disable iff (!resetn)
        !(rd_req && wr_req))
        else
        begin
            $error("rd_req and wr_req high together");
            fail_count++;
        end

    busy_blocks_cpu: assert property (@(posedge clk) disable iff (!resetn)
        state inside {cache_pkg::MISS, cache_pkg::REPLACE, cache_pkg::REFILL} |-> !addr_ok)
        else
        begin
            $error("addr_ok high during a miss");
            fail_count++;
        end

endmodule

bind cache_miss_control cache_assertions u_assertions (
    .clk          (clk),
    .resetn       (resetn),
    .state        (state),
    .addr_ok      (addr_ok),
    .rd_req       (rd_req),
    .rd_rdy       (rd_rdy),
    .wr_req       (wr_req),
    .wr_rdy       (wr_rdy),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data)
);

/* tests/cache_tb.sv */
`include "cache_config.svh"

module cache_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ACCEPT_TIMEOUT   = 20;
    localparam int RESPONSE_TIMEOUT = 200;
    localparam int RANDOM_REQUESTS  = 300;

    logic               clk;
    logic               resetn;
    logic               valid;
    logic               op;
    cache_pkg::tag_t    tag;
    cache_pkg::index_t  index;
    cache_pkg::offset_t offset;
    cache_pkg::strb_t   wstrb;
    cache_pkg::word_t   wdata;
    logic               addr_ok;
    logic               data_ok;
    cache_pkg::word_t   rdata;
    logic               rd_req;
    cache_pkg::addr_t   rd_addr;
    logic               rd_rdy;
    logic               ret_valid;
    logic               ret_last;
    cache_pkg::word_t   ret_data;
    logic               wr_req;
    cache_pkg::addr_t   wr_addr;
    cache_pkg::line_t   wr_data;
    logic               wr_rdy;

    cache_pkg::word_t ref_words [cache_pkg::addr_t];  // memory as the cpu sees it
    cache_pkg::word_t mem_words [cache_pkg::addr_t];  // backing memory model

    // shadow of the cache directory
    logic             sh_valid [2][`CACHE_SETS];
    logic             sh_dirty [2][`CACHE_SETS];
    cache_pkg::tag_t  sh_tag   [2][`CACHE_SETS];
    logic             sh_ptr   [`CACHE_SETS];

    // expectations for the request in flight
    logic             exp_read;
    logic             exp_miss;
    logic             exp_wb;
    cache_pkg::addr_t exp_line_addr;
    cache_pkg::addr_t exp_wb_addr;
    cache_pkg::word_t exp_rdata;

    int unsigned cycle_count;
    int unsigned accept_cycle;
    int unsigned resp_count;
    int unsigned rd_seen;
    int unsigned wr_seen;
    logic        in_flight;

    cache_top UUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic cache_pkg::word_t initial_word(input cache_pkg::addr_t a);
        return a ^ {a[7:0], a[31:8]} ^ 32'h6b3d_91c4;
    endfunction

    function automatic cache_pkg::word_t memory_word(input cache_pkg::addr_t a);
        return mem_words.exists(a) ? mem_words[a] : initial_word(a);
    endfunction

    // returns the word before the access and merges strobed bytes on a write
    function automatic cache_pkg::word_t reference_access(input logic wr,
                                                          input cache_pkg::addr_t a,
                                                          input cache_pkg::strb_t s,
                                                          input cache_pkg::word_t d);
        cache_pkg::word_t old;
        cache_pkg::word_t merged;
        old    = ref_words.exists(a) ? ref_words[a] : initial_word(a);
        merged = old;
        for (int b = 0; b < 4; b++)
        begin
            if (s[b])
            begin
                merged[b*8 +: 8] = d[b*8 +: 8];
            end
        end
        if (wr)
        begin
            ref_words[a] = merged;
        end
        return old;
    endfunction

    function automatic cache_pkg::line_t expected_line(input cache_pkg::addr_t line_addr);
        cache_pkg::line_t l;
        for (int w = 0; w < `CACHE_WORDS; w++)
        begin
            l[w*32 +: 32] = reference_access(1'b0, line_addr + cache_pkg::addr_t'(4 * w),
                                             4'h0, '0);
        end
        return l;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic serve_write();
        cache_pkg::addr_t a;
        cache_pkg::line_t l;
        begin
            repeat ($urandom_range(3)) @(posedge clk);
            #1;
            wr_rdy = 1'b1;
            @(posedge clk);  // transfer completes here
            a = wr_addr;
            l = wr_data;
            for (int w = 0; w < `CACHE_WORDS; w++)
            begin
                mem_words[a + cache_pkg::addr_t'(4 * w)] = l[w*32 +: 32];
            end
            #1;
            wr_rdy = 1'b0;
        end
    endtask

    task automatic serve_read();
        cache_pkg::addr_t a;
        begin
            repeat ($urandom_range(3)) @(posedge clk);
            #1;
            rd_rdy = 1'b1;
            @(posedge clk);
            a = rd_addr;
            #1;
            rd_rdy = 1'b0;
            for (int w = 0; w < `CACHE_WORDS; w++)
            begin
                repeat ($urandom_range(2))  // gap between beats
                begin
                    @(posedge clk);
                    #1;
                end
                ret_valid = 1'b1;
                ret_last  = (w == `CACHE_WORDS - 1);
                ret_data  = memory_word(a + cache_pkg::addr_t'(4 * w));
                @(posedge clk);
                #1;
                ret_valid = 1'b0;
                ret_last  = 1'b0;
            end
        end
    endtask

    initial
    begin : memory_model
        forever
        begin
            @(posedge clk);
            if (resetn && wr_req)
            begin
                serve_write();
            end
            else if (resetn && rd_req)
            begin
                serve_read();
            end
        end
    end

    task automatic do_request(input logic wr, input cache_pkg::tag_t t,
                              input cache_pkg::index_t ix, input cache_pkg::word_sel_t w,
                              input cache_pkg::strb_t s, input cache_pkg::word_t d);
        cache_pkg::addr_t a;
        logic             hit0;
        logic             hit1;
        cache_pkg::way_t  vic;
        int unsigned      target;
        int unsigned      waited;
        begin
            a    = {t, ix, w, 2'b00};
            hit0 = sh_valid[0][ix] && (sh_tag[0][ix] == t);
            hit1 = sh_valid[1][ix] && (sh_tag[1][ix] == t);
            vic  = !sh_valid[0][ix] ? 1'b0 : !sh_valid[1][ix] ? 1'b1 : sh_ptr[ix];
            exp_read      = !wr;
            exp_miss      = !(hit0 || hit1);
            exp_wb        = exp_miss && sh_dirty[vic][ix];
            exp_wb_addr   = {sh_tag[vic][ix], ix, 4'h0};
            exp_line_addr = {t, ix, 4'h0};
            exp_rdata     = reference_access(wr, a, s, d);
            target        = resp_count + 1;
            @(posedge clk);
            #1;
            valid  = 1'b1;
            op     = wr;
            tag    = t;
            index  = ix;
            offset = {w, 2'b00};
            wstrb  = s;
            wdata  = d;
            waited = 0;
            do
            begin
                @(posedge clk);
                waited++;
                if (waited > ACCEPT_TIMEOUT)
                    abort_run("Timed out waiting for addr_ok to accept a request");
            end
            while (!addr_ok);
            #1;
            valid  = 1'b0;
            waited = 0;
            while (resp_count != target)
            begin
                @(negedge clk);
                waited++;
                if (waited > RESPONSE_TIMEOUT)
                    abort_run("Timed out waiting for data_ok");
            end
            // shadow takes the refill and then the hit that follows it
            if (exp_miss)
            begin
                sh_valid[vic][ix] = 1'b1;
                sh_dirty[vic][ix] = 1'b0;
                sh_tag[vic][ix]   = t;
                if (sh_valid[0][ix] && sh_valid[1][ix])
                begin
                    sh_ptr[ix] = !sh_ptr[ix];
                end
            end
            if (wr)
            begin
                sh_dirty[exp_miss ? vic : hit1][ix] = 1'b1;
            end
        end
    endtask

    always @(posedge clk)
    begin
        if (resetn)
        begin
            cycle_count++;
            assert (UUT.u_miss_control.u_assertions.fail_count == 0)
                else abort_run("A protocol assertion on the controller failed");
            if (valid && addr_ok)
            begin
                accept_cycle = cycle_count;
                in_flight    = 1'b1;
                rd_seen      = 0;
                wr_seen      = 0;
            end
            if (wr_req && wr_rdy)
            begin
                assert (exp_wb && wr_seen == 0)
                    else abort_run($sformatf("ERROR at time %0t: unexpected write-back to %h",
                                             $time, wr_addr));
                assert (wr_addr == exp_wb_addr)
                    else abort_run($sformatf("ERROR at time %0t: wr_addr %h, expected %h",
                                             $time, wr_addr, exp_wb_addr));
                assert (wr_data == expected_line(wr_addr))
                    else abort_run($sformatf("ERROR at time %0t: wr_data %h, expected %h",
                                             $time, wr_data, expected_line(wr_addr)));
                wr_seen++;
            end
            if (rd_req && rd_rdy)
            begin
                assert (exp_miss && rd_seen == 0)
                    else abort_run($sformatf("ERROR at time %0t: unexpected refill of %h",
                                             $time, rd_addr));
                assert (rd_addr == exp_line_addr)
                    else abort_run($sformatf("ERROR at time %0t: rd_addr %h, expected %h",
                                             $time, rd_addr, exp_line_addr));
                rd_seen++;
            end
            if (data_ok)
            begin
                assert (in_flight)
                    else abort_run("data_ok came with no request in flight");
                assert (exp_miss || (cycle_count - accept_cycle == 2))
                    else abort_run($sformatf("ERROR at time %0t: hit took %0d cycles",
                                             $time, cycle_count - accept_cycle));
                assert (addr_ok)
                    else abort_run($sformatf("ERROR at time %0t: addr_ok low with data_ok",
                                             $time));
                assert (rd_seen == int'(exp_miss) && wr_seen == int'(exp_wb))
                    else abort_run($sformatf("ERROR at time %0t: %0d refills, %0d write-backs",
                                             $time, rd_seen, wr_seen));
                if (exp_read)
                begin
                    assert (rdata == exp_rdata)
                        else abort_run($sformatf("ERROR at time %0t: rdata %h, expected %h",
                                                 $time, rdata, exp_rdata));
                end
                in_flight = 1'b0;
                resp_count++;
            end
        end
    end

    initial
    begin
        cache_pkg::tag_t    rnd_tag;
        cache_pkg::index_t  rnd_index;
        void'($urandom(32'he191_9f98));
        resetn    = 1'b0;
        valid     = 1'b0;
        op        = 1'b0;
        tag       = '0;
        index     = '0;
        offset    = '0;
        wstrb     = '0;
        wdata     = '0;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;
        exp_read  = 1'b0;
        exp_miss  = 1'b0;
        exp_wb    = 1'b0;
        exp_rdata = '0;
        exp_line_addr = '0;
        exp_wb_addr   = '0;
        cycle_count   = 0;
        accept_cycle  = 0;
        resp_count    = 0;
        rd_seen       = 0;
        wr_seen       = 0;
        in_flight     = 1'b0;
        for (int i = 0; i < `CACHE_SETS; i++)
        begin
            sh_valid[0][i] = 1'b0;
            sh_valid[1][i] = 1'b0;
            sh_dirty[0][i] = 1'b0;
            sh_dirty[1][i] = 1'b0;
            sh_tag[0][i]   = '0;
            sh_tag[1][i]   = '0;
            sh_ptr[i]      = 1'b0;
        end
        repeat (16) @(posedge clk);
        #1;
        resetn = 1'b1;
        repeat (2)
        begin
            @(posedge clk);
            assert (addr_ok && !wr_req && !rd_req && !data_ok)
                else abort_run($sformatf("ERROR at time %0t: outputs not idle after reset",
                                         $time));
        end
        // fill both ways of one set, merge bytes and evict clean and dirty lines
        do_request(1'b0, 20'h0a001, 8'h21, 2'd1, 4'h0, 32'h0);
        do_request(1'b0, 20'h0a001, 8'h21, 2'd1, 4'h0, 32'h0);
        do_request(1'b1, 20'h0a001, 8'h21, 2'd1, 4'hf, 32'h1234_5678);
        do_request(1'b1, 20'h0a001, 8'h21, 2'd1, 4'b0101, 32'haabb_ccdd);
        do_request(1'b0, 20'h0a001, 8'h21, 2'd1, 4'h0, 32'h0);
        do_request(1'b1, 20'h0a001, 8'h21, 2'd3, 4'b1000, 32'h5500_0000);
        do_request(1'b0, 20'h0a002, 8'h21, 2'd0, 4'h0, 32'h0);
        do_request(1'b0, 20'h0a003, 8'h21, 2'd2, 4'h0, 32'h0);
        do_request(1'b0, 20'h0a004, 8'h21, 2'd3, 4'h0, 32'h0);
        do_request(1'b0, 20'h0a003, 8'h21, 2'd2, 4'h0, 32'h0);
        do_request(1'b0, 20'h0a001, 8'h21, 2'd1, 4'h0, 32'h0);
        do_request(1'b0, 20'h0a002, 8'h21, 2'd0, 4'h0, 32'h0);
        for (int n = 0; n < RANDOM_REQUESTS; n++)
        begin
            rnd_tag   = 20'h3c5a0 + cache_pkg::tag_t'($urandom_range(3));
            rnd_index = {2'($urandom_range(2)), 6'h15};  // three sets with four tags each
            do_request(1'($urandom_range(1)), rnd_tag, rnd_index,
                       cache_pkg::word_sel_t'($urandom_range(3)),
                       cache_pkg::strb_t'($urandom_range(15)), $urandom);
        end
        repeat (4) @(posedge clk);
        if (UUT.u_miss_control.u_assertions.fail_count == 0)
        begin
            $display("Testbench passed");
            $finish;
        end
        else
        begin
            abort_run("A protocol assertion on the controller failed");
        end
    end

endmodule

/* cache_two_way.f */
+incdir+include
source/cache_pkg.sv
source/cache_lookup.sv
source/cache_way_store.sv
source/cache_miss_control.sv
source/cache_response.sv
source/cache_top.sv
tests/cache_assertions.sv
tests/cache_tb.sv

/* Bender.yml */
package:
  name: cache_two_way

sources:
  - include_dirs:
      - include
    files:
      - source/cache_pkg.sv
      - source/cache_lookup.sv
      - source/cache_way_store.sv
      - source/cache_miss_control.sv
      - source/cache_response.sv
      - source/cache_top.sv
      - target: test
        files:
          - tests/cache_assertions.sv
          - tests/cache_tb.sv
